// ==== vlog.f ====
fifo_pkg.sv
fifo_mem_if.sv
fifo_wr_ctrl.sv
fifo_ram.sv
fifo_rd_ctrl.sv
fifo_buffer_top.sv
fifo_asserts.sv
tb_fifo_buffer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fifo testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_fifo_buffer -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_fifo_buffer.sv ====
`timescale 1ns/1ns

module tb_fifo_buffer;

    typedef enum {op_write, op_read, op_simul, op_clear, op_cfg, op_idle} op_e;

    localparam int wait_limit = 20;               // idle cycles allowed for a drain

    // dut ports
    logic             rd_clk;
    logic             rd_rst_n;
    logic             fifo_clear;
    logic             wr_en;
    fifo_pkg::data_t  wr_data;
    fifo_pkg::count_t prog_full_assert_cfg;
    fifo_pkg::count_t prog_full_negate_cfg;
    logic             full;
    logic             prog_full;
    logic             ovf_int;
    logic             rd_en;
    logic             empty;
    logic             prog_empty;
    logic             udf_int;
    fifo_pkg::data_t  rd_data;
    logic             rd_data_val;
    fifo_pkg::count_t data_count;

    // --------------------------------------------------
    // reference model state
    // --------------------------------------------------
    fifo_pkg::data_t  mq[$];                      // words stored, oldest first
    fifo_pkg::data_t  fl_data[$];                 // reads in flight
    int               fl_due[$];                  // cycle each one must show valid
    int               cyc = 0;                    // edges seen by the driver
    logic             pf_m = 1'b0;                // predicted prog_full
    logic             pe_m = 1'b1;                // predicted prog_empty
    fifo_pkg::count_t cfg_a;
    fifo_pkg::count_t cfg_n;
    int               ovf_exp = 0;
    int               udf_exp = 0;
    int               ovf_seen = 0;
    int               udf_seen = 0;
    string            cur_name = "reset";

    // stimulus table, one entry per row
    string row_name[$];
    op_e   row_op[$];
    int    row_cnt[$];
    int    row_a[$];
    int    row_n[$];

    fifo_buffer_top dut0 (.*);

    bind fifo_rd_ctrl fifo_asserts u_asserts (
        .rd_clk      ( rd_clk      ),
        .rd_rst_n    ( rd_rst_n    ),
        .fifo_clear  ( fifo_clear  ),
        .ren         ( mif.ren     ),
        .empty       ( empty       ),
        .wr_ptr      ( mif.wr_ptr  ),
        .rd_ptr      ( rd_ptr      ),
        .rd_data_val ( rd_data_val ),
        .data_count  ( data_count  )
    );

    initial begin
        rd_clk = 1'b0;
        forever #50 rd_clk = ~rd_clk;             // 100 ns period
    end

    // --------------------------------------------------
    // failure and compare tasks
    // --------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input fifo_pkg::data_t exp,
                              input fifo_pkg::data_t act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input fifo_pkg::count_t exp,
                               input fifo_pkg::count_t act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    task automatic add_row(input string name, input op_e op, input int cnt,
                           input int a, input int n);
        row_name.push_back(name);
        row_op.push_back(op);
        row_cnt.push_back(cnt);
        row_a.push_back(a);
        row_n.push_back(n);
    endtask

    // --------------------------------------------------
    // one clock of stimulus plus the model of the edge it meets
    // --------------------------------------------------
    task automatic cycle(input logic we, input logic re, input logic clr);
        fifo_pkg::data_t d;
        int              occ;
        @(posedge rd_clk);
        cyc++;
        d   = {$urandom(), $urandom(), $urandom(), $urandom()};
        occ = mq.size();
        wr_en                <= we;
        rd_en                <= re;
        fifo_clear           <= clr;
        wr_data              <= d;
        prog_full_assert_cfg <= cfg_a;
        prog_full_negate_cfg <= cfg_n;
        if (we && occ == fifo_pkg::FIFO_DEPTH) ovf_exp++;   // write hits full
        if (re && occ == 0) udf_exp++;                      // read hits empty
        if (clr) begin
            pf_m = 1'b0;
            pe_m = 1'b1;
            mq.delete();
            // reads not yet on the output are lost
            while (fl_due.size() != 0 && fl_due[fl_due.size()-1] > cyc) begin
                fl_due.delete(fl_due.size() - 1);
                fl_data.delete(fl_data.size() - 1);
            end
        end else begin
            if (occ >= int'(cfg_a)) pf_m = 1'b1;            // hysteresis
            else if (occ < int'(cfg_n)) pf_m = 1'b0;
            if (occ <= fifo_pkg::PROG_EMPTY_ASSERT) pe_m = 1'b1;
            else if (occ > fifo_pkg::PROG_EMPTY_NEGATE) pe_m = 1'b0;
            if (re && occ > 0) begin
                fl_data.push_back(mq[0]);
                fl_due.push_back(cyc + 2);                  // two edges after accept
                mq.delete(0);
            end
            if (we && occ < fifo_pkg::FIFO_DEPTH) mq.push_back(d);
        end
    endtask

    // flags and counters once the fifo is quiet
    task automatic check_state();
        check_flag({cur_name, " full"}, mq.size() == fifo_pkg::FIFO_DEPTH, full);
        check_flag({cur_name, " empty"}, mq.size() == 0, empty);
        check_flag({cur_name, " prog_full"}, pf_m, prog_full);
        check_flag({cur_name, " prog_empty"}, pe_m, prog_empty);
        check_flag({cur_name, " ovf_int"}, 1'b0, ovf_int);
        check_flag({cur_name, " udf_int"}, 1'b0, udf_int);
        check_count({cur_name, " data_count"},
                    fifo_pkg::count_t'(mq.size() + fl_data.size()), data_count);
        check_count({cur_name, " ovf pulses"}, fifo_pkg::count_t'(ovf_exp),
                    fifo_pkg::count_t'(ovf_seen));
        check_count({cur_name, " udf pulses"}, fifo_pkg::count_t'(udf_exp),
                    fifo_pkg::count_t'(udf_seen));
    endtask

    task automatic settle();
        int n;
        cycle(1'b0, 1'b0, 1'b0);                  // last op lands
        cycle(1'b0, 1'b0, 1'b0);                  // prog flags catch up
        n = 0;
        while (fl_due.size() != 0) begin
            if (n == wait_limit)
                fail_run($sformatf("%s timed out waiting for rd_data_val", cur_name));
            cycle(1'b0, 1'b0, 1'b0);
            n++;
        end
        @(negedge rd_clk);
        check_state();
    endtask

    // output side sampled mid cycle
    always @(negedge rd_clk) begin : monitor
        logic val_exp;
        val_exp = 1'b0;
        if (fl_due.size() != 0) val_exp = (fl_due[0] == cyc);
        check_flag({cur_name, " rd_data_val"}, val_exp, rd_data_val);
        if (rd_data_val === 1'b1) begin
            check_data({cur_name, " rd_data"}, fl_data[0], rd_data);
            fl_data.delete(0);
            fl_due.delete(0);
        end
        if (ovf_int === 1'b1) ovf_seen++;
        if (udf_int === 1'b1) udf_seen++;
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(98866));
        rd_rst_n             = 1'b0;
        fifo_clear           = 1'b0;
        wr_en                = 1'b0;
        rd_en                = 1'b0;
        wr_data              = '0;
        cfg_a                = 5'd14;
        cfg_n                = 5'd10;
        prog_full_assert_cfg = cfg_a;
        prog_full_negate_cfg = cfg_n;

        //      name           op        cnt  a   n
        add_row("fill_random", op_write, 6,   0,  0);
        add_row("drain_b2b",   op_read,  6,   0,  0);
        add_row("refill_5",    op_write, 5,   0,  0);
        add_row("simul_rw",    op_simul, 8,   0,  0);
        add_row("drain_5",     op_read,  5,   0,  0);
        add_row("underflow",   op_read,  3,   0,  0);
        add_row("cfg_12_8",    op_cfg,   1,   12, 8);
        add_row("fill_11",     op_write, 11,  0,  0);
        add_row("fill_12",     op_write, 1,   0,  0);
        add_row("drain_to_8",  op_read,  4,   0,  0);
        add_row("drain_to_7",  op_read,  1,   0,  0);
        add_row("fill_16",     op_write, 9,   0,  0);
        add_row("overflow",    op_write, 1,   0,  0);
        add_row("drain_all",   op_read,  16,  0,  0);
        add_row("pe_above_4",  op_write, 5,   0,  0);
        add_row("pe_at_4",     op_read,  1,   0,  0);
        add_row("partial",     op_write, 3,   0,  0);
        add_row("clear",       op_clear, 1,   0,  0);
        add_row("after_clear", op_write, 1,   0,  0);
        add_row("read_back",   op_read,  1,   0,  0);
        add_row("idle",        op_idle,  2,   0,  0);

        repeat (8) @(posedge rd_clk);
        rd_rst_n <= 1'b1;
        @(negedge rd_clk);
        check_state();                            // reset values

        for (int i = 0; i < row_name.size(); i++) begin
            cur_name = row_name[i];
            case (row_op[i])
                op_write: repeat (row_cnt[i]) cycle(1'b1, 1'b0, 1'b0);
                op_read:  repeat (row_cnt[i]) cycle(1'b0, 1'b1, 1'b0);
                op_simul: repeat (row_cnt[i]) cycle(1'b1, 1'b1, 1'b0);
                op_clear: cycle(1'b0, 1'b0, 1'b1);
                op_cfg: begin
                    cfg_a = fifo_pkg::count_t'(row_a[i]);
                    cfg_n = fifo_pkg::count_t'(row_n[i]);
                    cycle(1'b0, 1'b0, 1'b0);
                end
                default:  repeat (row_cnt[i]) cycle(1'b0, 1'b0, 1'b0);
            endcase
            settle();
        end

        if (dut0.u_rd_ctrl.u_asserts.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("a concurrent assertion failed during the run");
        end
    end

endmodule

// ==== fifo_asserts.sv ====
`timescale 1ns/1ns

module fifo_asserts (
    input logic             rd_clk,
    input logic             rd_rst_n,
    input logic             fifo_clear,
    input logic             ren,           // accepted read
    input logic             empty,
    input fifo_pkg::ptr_t   wr_ptr,        // producer pointer
    input fifo_pkg::ptr_t   rd_ptr,        // consumer pointer
    input logic             rd_data_val,
    input fifo_pkg::count_t data_count
);

    int fail_cnt = 0;                      // failed assertions so far

    // --------------------------------------------------
    // read pipeline timing
    // --------------------------------------------------

    // accepted read shows valid two edges later, unless a clear drops it
    valid_after_read: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        (ren && !fifo_clear) ##1 !fifo_clear |=> rd_data_val)
        else begin
            fail_cnt++;
            $error("rd_data_val missing two cycles after an accepted read");
        end

    // no valid without a read two cycles back
    read_before_valid: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        rd_data_val |-> $past(ren, 2))
        else begin
            fail_cnt++;
            $error("rd_data_val without an accepted read two cycles before");
        end

    // --------------------------------------------------
    // occupancy limits
    // --------------------------------------------------

    // empty flag exact against the pointers, so no read can pass an empty ram
    empty_matches_pointers: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        empty == (wr_ptr == rd_ptr))
        else begin
            fail_cnt++;
            $error("empty flag disagrees with the pointers");
        end

    count_in_range: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        data_count <= fifo_pkg::count_t'(fifo_pkg::FIFO_DEPTH))
        else begin
            fail_cnt++;
            $error("data_count above fifo depth");
        end

endmodule

// ==== fifo_buffer_top.sv ====
`timescale 1ns/1ns

module fifo_buffer_top (
    input  logic                rd_clk,
    input  logic                rd_rst_n,
    input  logic                fifo_clear,
    // write side
    input  logic                wr_en,
    input  fifo_pkg::data_t     wr_data,
    input  fifo_pkg::count_t    prog_full_assert_cfg,
    input  fifo_pkg::count_t    prog_full_negate_cfg,
    output logic                full,
    output logic                prog_full,
    output logic                ovf_int,
    // read side
    input  logic                rd_en,
    output logic                empty,
    output logic                prog_empty,
    output logic                udf_int,
    output fifo_pkg::data_t     rd_data,
    output logic                rd_data_val,
    output fifo_pkg::count_t    data_count
);

    // --------------------------------------------------
    // producer, buffer, consumer
    // --------------------------------------------------
    fifo_mem_if mif ();                               // shared pointer and ram bus

    fifo_wr_ctrl u_wr_ctrl (
        .rd_clk               ( rd_clk               ),
        .rd_rst_n             ( rd_rst_n             ),
        .fifo_clear           ( fifo_clear           ),
        .wr_en                ( wr_en                ),
        .wr_data              ( wr_data              ),
        .prog_full_assert_cfg ( prog_full_assert_cfg ),
        .prog_full_negate_cfg ( prog_full_negate_cfg ),
        .full                 ( full                 ),
        .prog_full            ( prog_full            ),
        .ovf_int              ( ovf_int              ),
        .mif                  ( mif.wr_side          )
    );

    // behavioral dual-port ram
    fifo_ram u_ram (
        .rd_clk               ( rd_clk               ),
        .mif                  ( mif.mem_side         )
    );

    fifo_rd_ctrl u_rd_ctrl (
        .rd_clk               ( rd_clk               ),
        .rd_rst_n             ( rd_rst_n             ),
        .fifo_clear           ( fifo_clear           ),
        .rd_en                ( rd_en                ),
        .empty                ( empty                ),
        .prog_empty           ( prog_empty           ),
        .udf_int              ( udf_int              ),
        .rd_data_val          ( rd_data_val          ),
        .rd_data              ( rd_data              ),
        .data_count           ( data_count           ),
        .mif                  ( mif.rd_side          )
    );

endmodule

// ==== fifo_rd_ctrl.sv ====
`timescale 1ns/1ns

module fifo_rd_ctrl (
    input  logic                rd_clk,
    input  logic                rd_rst_n,
    input  logic                fifo_clear,       // sync clear, wins over normal op
    input  logic                rd_en,
    output logic                empty,
    output logic                prog_empty,
    output logic                udf_int,          // one-cycle underflow pulse
    output logic                rd_data_val,
    output fifo_pkg::data_t     rd_data,
    output fifo_pkg::count_t    data_count,       // written but not yet delivered
    fifo_mem_if.rd_side         mif
);

    fifo_pkg::ptr_t   rd_ptr;                     // read pointer, msb is wrap
    fifo_pkg::ptr_t   dlv_ptr;                    // delivered words counter
    fifo_pkg::count_t occ;                        // current occupancy
    fifo_pkg::count_t occ_nxt;                    // occupancy after this edge
    logic [fifo_pkg::RAM_PIPE_STAGE-1:0] val_pipe; // ren delay line

    // --------------------------------------------------
    // read accept and ram read port
    // --------------------------------------------------
    assign mif.ren    = rd_en & ~empty;                  // no read from an empty fifo
    assign mif.raddr  = fifo_pkg::addr_t'(rd_ptr);
    assign mif.rd_ptr = rd_ptr;

    assign occ     = fifo_pkg::occupancy(mif.wr_ptr, rd_ptr);
    assign occ_nxt = fifo_pkg::next_occupancy(occ, mif.wen, mif.ren);

    // read pointer
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_ptr <= '0;
        end else if (fifo_clear) begin
            rd_ptr <= '0;
        end else if (mif.ren) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // --------------------------------------------------
    // flags
    // --------------------------------------------------

    // empty is exact one cycle after the edge
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            empty <= 1'b1;
        end else if (fifo_clear) begin
            empty <= 1'b1;
        end else begin
            empty <= (occ_nxt == '0);
        end
    end

    // almost empty, fixed levels, lags occupancy by one cycle
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            prog_empty <= 1'b1;
        end else if (fifo_clear) begin
            prog_empty <= 1'b1;
        end else if (occ <= fifo_pkg::count_t'(fifo_pkg::PROG_EMPTY_ASSERT)) begin
            prog_empty <= 1'b1;
        end else if (occ > fifo_pkg::count_t'(fifo_pkg::PROG_EMPTY_NEGATE)) begin
            prog_empty <= 1'b0;
        end
    end

    // underflow pulse
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            udf_int <= 1'b0;
        end else begin
            udf_int <= rd_en & empty;
        end
    end

    // --------------------------------------------------
    // output data and valid
    // --------------------------------------------------

    // matches the ram read latency, clear drops reads in flight
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            val_pipe <= '0;
        end else if (fifo_clear) begin
            val_pipe <= '0;
        end else begin
            val_pipe <= {val_pipe[fifo_pkg::RAM_PIPE_STAGE-2:0], mif.ren};
        end
    end

    assign rd_data_val = val_pipe[fifo_pkg::RAM_PIPE_STAGE-1];
    assign rd_data     = mif.rdata;                   // no output back-pressure

    // delivered counter, steps on each valid word
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            dlv_ptr <= '0;
        end else if (fifo_clear) begin
            dlv_ptr <= '0;
        end else if (rd_data_val) begin
            dlv_ptr <= dlv_ptr + 1'b1;
        end
    end

    // counts words still inside ram or read pipe
    assign data_count = fifo_pkg::occupancy(mif.wr_ptr, dlv_ptr);

endmodule

// ==== fifo_ram.sv ====
`timescale 1ns/1ns

module fifo_ram (
    input  logic         rd_clk,
    fifo_mem_if.mem_side mif
);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    fifo_pkg::data_t mem [fifo_pkg::FIFO_DEPTH];   // 16 x 128

    fifo_pkg::addr_t raddr_q;      // stage 1, captured read address
    fifo_pkg::data_t rdata_q;      // stage 2, registered word

    // synchronous write
    always_ff @(posedge rd_clk) begin
        if (mif.wen) begin
            mem[mif.waddr] <= mif.wdata;
        end
    end

    // --------------------------------------------------
    // two-stage read
    // --------------------------------------------------

    // address only moves on an accepted read
    always_ff @(posedge rd_clk) begin
        if (mif.ren) begin
            raddr_q <= mif.raddr;
        end
    end

    // word follows the held address every cycle
    // a write to the same slot on this edge is not seen, slot was already freed
    always_ff @(posedge rd_clk) begin
        rdata_q <= mem[raddr_q];
    end

    assign mif.rdata = rdata_q;    // valid two cycles after ren

endmodule

// ==== fifo_wr_ctrl.sv ====
`timescale 1ns/1ns

module fifo_wr_ctrl (
    input  logic                rd_clk,
    input  logic                rd_rst_n,
    input  logic                fifo_clear,           // sync clear, wins over normal op
    input  logic                wr_en,
    input  fifo_pkg::data_t     wr_data,
    input  fifo_pkg::count_t    prog_full_assert_cfg, // almost-full set level
    input  fifo_pkg::count_t    prog_full_negate_cfg, // almost-full clear level
    output logic                full,
    output logic                prog_full,
    output logic                ovf_int,              // one-cycle overflow pulse
    fifo_mem_if.wr_side         mif
);

    fifo_pkg::ptr_t   wr_ptr;      // write pointer, msb is wrap
    fifo_pkg::count_t occ;         // current occupancy
    fifo_pkg::count_t occ_nxt;     // occupancy after this edge

    // --------------------------------------------------
    // write accept and ram write port
    // --------------------------------------------------
    assign mif.wen    = wr_en & ~full;                     // drop writes while full
    assign mif.waddr  = fifo_pkg::addr_t'(wr_ptr);         // low bits address the ram
    assign mif.wdata  = wr_data;
    assign mif.wr_ptr = wr_ptr;

    // occupancy against the consumer's pointer
    assign occ     = fifo_pkg::occupancy(wr_ptr, mif.rd_ptr);
    assign occ_nxt = fifo_pkg::next_occupancy(occ, mif.wen, mif.ren);

    // write pointer
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            wr_ptr <= '0;
        end else if (fifo_clear) begin
            wr_ptr <= '0;
        end else if (mif.wen) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // --------------------------------------------------
    // flags
    // --------------------------------------------------

    // full is exact one cycle after the edge
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            full <= 1'b0;
        end else if (fifo_clear) begin
            full <= 1'b0;
        end else begin
            full <= (occ_nxt == fifo_pkg::count_t'(fifo_pkg::FIFO_DEPTH));
        end
    end

    // almost full with hysteresis between the two levels
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            prog_full <= 1'b0;
        end else if (fifo_clear) begin
            prog_full <= 1'b0;
        end else if (occ >= prog_full_assert_cfg) begin
            prog_full <= 1'b1;                             // reached set level
        end else if (occ < prog_full_negate_cfg) begin
            prog_full <= 1'b0;                             // drained below clear level
        end
    end

    // overflow pulse, write attempted while full
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            ovf_int <= 1'b0;
        end else begin
            ovf_int <= wr_en & full;
        end
    end

endmodule

// ==== fifo_mem_if.sv ====
`timescale 1ns/1ns

interface fifo_mem_if;

    // --------------------------------------------------
    // write side, from the write controller
    // --------------------------------------------------
    logic            wen;      // accepted write this cycle
    fifo_pkg::addr_t waddr;    // ram write address
    fifo_pkg::data_t wdata;    // ram write data
    fifo_pkg::ptr_t  wr_ptr;   // write pointer with wrap bit

    // --------------------------------------------------
    // read side, from the read controller
    // --------------------------------------------------
    logic            ren;      // accepted read this cycle
    fifo_pkg::addr_t raddr;    // ram read address
    fifo_pkg::ptr_t  rd_ptr;   // read pointer with wrap bit

    // ram output, two cycles behind ren
    fifo_pkg::data_t rdata;

    // producer
    modport wr_side (
        output wen, waddr, wdata, wr_ptr,
        input  ren, rd_ptr
    );

    // consumer, needs wen too so that empty sees a write in the same cycle
    modport rd_side (
        output ren, raddr, rd_ptr,
        input  wr_ptr, wen, rdata
    );

    // storage
    modport mem_side (
        input  wen, waddr, wdata, ren, raddr,
        output rdata
    );

endinterface

// ==== fifo_pkg.sv ====
package fifo_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int ADDR_WIDTH     = 4;                   // ram address bits
    localparam int FIFO_DEPTH     = 1 << ADDR_WIDTH;     // 16 entries
    localparam int DATA_WIDTH     = 128;                 // payload bits
    localparam int RAM_PIPE_STAGE = 2;                   // accepted read to data valid

    // almost-empty thresholds, fixed
    localparam int PROG_EMPTY_ASSERT = 4;                // set at or below
    localparam int PROG_EMPTY_NEGATE = 4;                // clear above

    // --------------------------------------------------
    // shared types
    // --------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0] addr_t;               // ram address
    typedef logic [ADDR_WIDTH:0]   ptr_t;                // address plus wrap bit
    typedef logic [ADDR_WIDTH:0]   count_t;              // occupancy 0..16
    typedef logic [DATA_WIDTH-1:0] data_t;               // payload word

    // occupancy seen from a pair of pointers
    // the wrap bit makes the modulo difference exact for 0..16
    function automatic count_t occupancy(input ptr_t wr_ptr, input ptr_t rd_ptr);
        ptr_t diff;
        diff = wr_ptr - rd_ptr;
        return count_t'(diff);
    endfunction

    // occupancy after the current cycle's accepted write and read
    function automatic count_t next_occupancy(input count_t occ,
                                              input logic   wen,
                                              input logic   ren);
        count_t nxt;
        nxt = occ + count_t'(wen) - count_t'(ren);
        return nxt;
    endfunction

endpackage
